/* design/audio_dac.sv */
/*
 * first-order sigma-delta DAC
 *   one PDM bit per clock from the accumulator carry
 */
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_dac #(
    parameter int WIDTH = `AUDIO_DAC_W
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [WIDTH-1:0]    value_i,
    output logic                pulse_o
);
    logic [WIDTH-1:0] accum;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            accum   <= '0;
            pulse_o <= 1'b0;
        end else begin
            {pulse_o, accum} <= {1'b0, accum} + value_i;   // carry is the pulse
        end
    end

endmodule

/* design/audio_defines.svh */
/*
 * audio block build constants
 *   channel count and channel index width
 *   sample-memory address width, DAC width, APB address width
 *   APB register offsets and the sample-memory region
 */
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

`define AUDIO_NCHAN         4               // playback channels
`define AUDIO_CHAN_W        2               // channel index width
`define AUDIO_VRAM_W        10              // sample memory word address width
`define AUDIO_DAC_W         8               // sigma-delta input width
`define AUDIO_APB_AW        12              // APB byte address width

// register map, byte addresses
`define AUDIO_REG_CTRL      12'h000         // [3:0] enable, [7:4] restart
`define AUDIO_REG_STATUS    12'h004         // sticky reload bits, read clears
`define AUDIO_REG_CHAN      12'h040         // 16-byte block per channel
`define AUDIO_MEM_BASE      12'h800         // bit 11 set selects sample memory

`endif

/* design/audio_mixer.sv */
/*
 * four-channel sample playback and mixing
 *   per-channel period and length underflow counters
 *   round-robin word fetch sequencer
 *   time-shared multiply-accumulate, left and right DACs
 */
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_mixer (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [`AUDIO_NCHAN-1:0]             chan_enable_i,
    input  logic [`AUDIO_NCHAN-1:0]             chan_restart_i,
    input  logic [6*`AUDIO_NCHAN-1:0]           chan_vol_l_i,
    input  logic [6*`AUDIO_NCHAN-1:0]           chan_vol_r_i,
    input  logic [15*`AUDIO_NCHAN-1:0]          chan_period_i,
    input  logic [`AUDIO_VRAM_W*`AUDIO_NCHAN-1:0] chan_start_i,
    input  logic [15*`AUDIO_NCHAN-1:0]          chan_len_i,
    output logic [`AUDIO_NCHAN-1:0]             chan_reload_o,
    output logic                                fetch_req_o,
    output audio_sample_pkg::addr_t             fetch_addr_o,
    input  logic                                fetch_ack_i,
    input  audio_sample_pkg::word_t             fetch_word_i,
    output logic                                pdm_l_o,
    output logic                                pdm_r_o
);
    import audio_sample_pkg::*;

    logic [15:0]                period_cnt [`AUDIO_NCHAN];  // bit 15 is underflow
    logic [15:0]                length_cnt [`AUDIO_NCHAN];  // bit 15 is underflow
    addr_t                      chan_addr [`AUDIO_NCHAN];   // next word to fetch
    word_t                      chan_buf [`AUDIO_NCHAN];
    sbyte_t                     chan_val [`AUDIO_NCHAN];    // sample being played
    sbyte_t                     chan_val2 [`AUDIO_NCHAN];   // low byte waiting
    logic [`AUDIO_NCHAN-1:0]    chan_2nd;
    logic [`AUDIO_NCHAN-1:0]    chan_buf_ok;
    logic [`AUDIO_NCHAN-1:0]    chan_fetch;
    logic [`AUDIO_NCHAN-1:0]    chan_output;

    logic [`AUDIO_CHAN_W-1:0]   fetch_chan;
    fetch_phase_e               fetch_phase;
    logic [`AUDIO_CHAN_W-1:0]   mix_chan;
    mix_phase_e                 mix_phase;

    sbyte_t                     mix_val;
    sbyte_t                     vol_l_tmp;
    sbyte_t                     vol_r_tmp;
    sword_t                     mult_l;
    sword_t                     mult_r;
    sword_t                     accum_l;
    sword_t                     accum_r;
    logic [`AUDIO_DAC_W-1:0]    level_l;
    logic [`AUDIO_DAC_W-1:0]    level_r;

    always_comb begin
        for (int i = 0; i < `AUDIO_NCHAN; i++) begin
            chan_output[i] = period_cnt[i][15] && chan_enable_i[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            chan_reload_o <= '0;
            chan_2nd      <= '0;
            chan_buf_ok   <= '0;
            chan_fetch    <= '0;
            fetch_req_o   <= 1'b0;
            fetch_chan    <= '0;
            fetch_phase   <= FETCH_DMA;
            for (int i = 0; i < `AUDIO_NCHAN; i++) begin
                period_cnt[i] <= 16'h8000;
                length_cnt[i] <= 16'h8000;
                chan_val[i]   <= '0;
                chan_val2[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < `AUDIO_NCHAN; i++) begin
                chan_reload_o[i] <= 1'b0;
                period_cnt[i]    <= period_cnt[i] - 16'd1;
                if (chan_output[i]) begin
                    period_cnt[i] <= {1'b0, chan_period_i[15*i +: 15]} - 16'd1;
                    if (chan_2nd[i]) begin
                        chan_val[i]   <= chan_val2[i];
                        chan_2nd[i]   <= 1'b0;
                        chan_fetch[i] <= 1'b1;
                        if (length_cnt[i][15] || length_cnt[i] == 16'd0) begin
                            chan_addr[i]     <= chan_start_i[`AUDIO_VRAM_W*i +: `AUDIO_VRAM_W];
                            length_cnt[i]    <= {1'b0, chan_len_i[15*i +: 15]};
                            chan_reload_o[i] <= 1'b1;
                        end else begin
                            chan_addr[i]  <= chan_addr[i] + 1'b1;
                            length_cnt[i] <= length_cnt[i] - 16'd1;
                        end
                    end else if (chan_buf_ok[i]) begin
                        chan_val[i]    <= chan_buf[i][15:8];
                        chan_val2[i]   <= chan_buf[i][7:0];
                        chan_buf_ok[i] <= 1'b0;
                        chan_2nd[i]    <= 1'b1;
                    end                                 // late fetch keeps last sample
                end
                if (chan_restart_i[i] || !chan_enable_i[i]) begin
                    length_cnt[i][15] <= 1'b1;          // reload on next output
                    period_cnt[i][15] <= 1'b1;
                    chan_2nd[i]       <= 1'b1;
                    chan_buf_ok[i]    <= 1'b0;
                end
                if (!chan_enable_i[i]) begin
                    chan_val[i]  <= '0;                 // silent
                    chan_val2[i] <= '0;
                end
            end

            case (fetch_phase)
                FETCH_DMA: begin
                    fetch_req_o  <= chan_fetch[fetch_chan] && !chan_buf_ok[fetch_chan];
                    fetch_addr_o <= chan_addr[fetch_chan];
                    fetch_phase  <= FETCH_READ;
                end
                default: begin
                    if (!fetch_req_o) begin
                        fetch_chan  <= fetch_chan + 1'b1;
                        fetch_phase <= FETCH_DMA;
                    end else if (fetch_ack_i) begin
                        fetch_req_o             <= 1'b0;
                        chan_fetch[fetch_chan]  <= 1'b0;
                        chan_buf[fetch_chan]    <= fetch_word_i;
                        chan_buf_ok[fetch_chan] <= 1'b1;
                        fetch_chan              <= fetch_chan + 1'b1;
                        fetch_phase             <= FETCH_DMA;
                    end
                end
            endcase
        end
    end

    assign mult_l = mix_val * vol_l_tmp;
    assign mult_r = mix_val * vol_r_tmp;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_chan  <= '0;
            mix_phase <= MIX_MULT;
            mix_val   <= '0;
            vol_l_tmp <= '0;
            vol_r_tmp <= '0;
            accum_l   <= '0;
            accum_r   <= '0;
            level_l   <= 8'h80;                         // mid scale
            level_r   <= 8'h80;
        end else begin
            case (mix_phase)
                MIX_MULT: begin
                    if (mix_chan == '0) begin
                        level_l <= {~accum_l[15], accum_l[12:6]};   // offset binary
                        level_r <= {~accum_r[15], accum_r[12:6]};
                        accum_l <= '0;
                        accum_r <= '0;
                    end
                    mix_val   <= chan_val[mix_chan];
                    vol_l_tmp <= {1'b0, chan_vol_l_i[mix_chan*6 +: 6], 1'b0};  // 2 x volume
                    vol_r_tmp <= {1'b0, chan_vol_r_i[mix_chan*6 +: 6], 1'b0};
                    mix_phase <= MIX_ACCUM;
                end
                default: begin
                    accum_l   <= accum_l + mult_l;
                    accum_r   <= accum_r + mult_r;
                    mix_chan  <= mix_chan + 1'b1;
                    mix_phase <= MIX_MULT;
                end
            endcase
        end
    end

    audio_dac #(.WIDTH(`AUDIO_DAC_W)) dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (level_l),
        .pulse_o (pdm_l_o)
    );

    audio_dac #(.WIDTH(`AUDIO_DAC_W)) dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (level_r),
        .pulse_o (pdm_r_o)
    );

endmodule

/* design/audio_regmap_pkg.sv */
/*
 * register map types for the audio block
 *   register select within a channel block
 *   per-channel field types
 */
package audio_regmap_pkg;

    // selected by address bits 3:2 inside a channel block
    typedef enum logic [1:0] {
        REG_VOL    = 2'd0,                          // [13:8] left, [5:0] right
        REG_PERIOD = 2'd1,
        REG_START  = 2'd2,
        REG_LEN    = 2'd3
    } reg_sel_e;

    typedef logic [5:0]     vol_t;                  // channel volume
    typedef logic [14:0]    period_t;               // cycles per sample minus one
    typedef logic [14:0]    len_t;                  // words per buffer minus one

endpackage

/* design/audio_regs.sv */
/*
 * APB register slave for the audio block
 *   channel volume, period, start and length registers
 *   enable bits and restart strobes from CTRL
 *   read-to-clear reload status, sample memory write port
 */
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_regs (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [`AUDIO_APB_AW-1:0]            paddr_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [31:0]                         pwdata_i,
    output logic [31:0]                         prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output logic [`AUDIO_NCHAN-1:0]             chan_enable_o,
    output logic [`AUDIO_NCHAN-1:0]             chan_restart_o,
    output logic [6*`AUDIO_NCHAN-1:0]           chan_vol_l_o,
    output logic [6*`AUDIO_NCHAN-1:0]           chan_vol_r_o,
    output logic [15*`AUDIO_NCHAN-1:0]          chan_period_o,
    output logic [`AUDIO_VRAM_W*`AUDIO_NCHAN-1:0] chan_start_o,
    output logic [15*`AUDIO_NCHAN-1:0]          chan_len_o,
    input  logic [`AUDIO_NCHAN-1:0]             chan_reload_i,
    output logic                                mem_we_o,
    output audio_sample_pkg::addr_t             mem_waddr_o,
    output audio_sample_pkg::word_t             mem_wdata_o
);
    import audio_sample_pkg::*;
    import audio_regmap_pkg::*;

    vol_t                       vol_l [`AUDIO_NCHAN];
    vol_t                       vol_r [`AUDIO_NCHAN];
    period_t                    period [`AUDIO_NCHAN];
    addr_t                      start [`AUDIO_NCHAN];
    len_t                       len [`AUDIO_NCHAN];
    logic [`AUDIO_NCHAN-1:0]    status;             // sticky reload bits

    logic                       wr;
    logic                       rd;
    logic                       is_mem;
    logic                       is_ctrl;
    logic                       is_status;
    logic                       is_chan;
    logic [`AUDIO_CHAN_W-1:0]   chan_idx;
    reg_sel_e                   reg_sel;

    assign wr        = psel_i && penable_i && pwrite_i;     // ACCESS phase only
    assign rd        = psel_i && penable_i && !pwrite_i;
    assign is_mem    = (paddr_i & `AUDIO_MEM_BASE) != '0;
    assign is_ctrl   = paddr_i == `AUDIO_REG_CTRL;
    assign is_status = paddr_i == `AUDIO_REG_STATUS;
    assign is_chan   = {paddr_i[11:6], 6'd0} == `AUDIO_REG_CHAN;
    assign chan_idx  = paddr_i[4 +: `AUDIO_CHAN_W];
    assign reg_sel   = reg_sel_e'(paddr_i[3:2]);

    assign pready_o  = 1'b1;                        // no wait states
    assign pslverr_o = psel_i && penable_i &&
                       ((is_mem && !pwrite_i) || !(is_mem || is_ctrl || is_status || is_chan));

    assign mem_we_o    = wr && is_mem;
    assign mem_waddr_o = paddr_i[10:1];             // 16-bit words
    assign mem_wdata_o = pwdata_i[15:0];

    always_comb begin
        prdata_o = '0;
        if (is_ctrl) begin
            prdata_o[`AUDIO_NCHAN-1:0] = chan_enable_o;     // restart bits read as 0
        end else if (is_status) begin
            prdata_o[`AUDIO_NCHAN-1:0] = status;
        end else if (is_chan) begin
            case (reg_sel)
                REG_VOL: begin
                    prdata_o[13:8] = vol_l[chan_idx];
                    prdata_o[5:0]  = vol_r[chan_idx];
                end
                REG_PERIOD: prdata_o[14:0] = period[chan_idx];
                REG_START:  prdata_o[`AUDIO_VRAM_W-1:0] = start[chan_idx];
                default:    prdata_o[14:0] = len[chan_idx];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            chan_enable_o  <= '0;
            chan_restart_o <= '0;
            status         <= '0;
            for (int i = 0; i < `AUDIO_NCHAN; i++) begin
                vol_l[i]  <= '0;
                vol_r[i]  <= '0;
                period[i] <= '0;
                start[i]  <= '0;
                len[i]    <= '0;
            end
        end else begin
            chan_restart_o <= '0;
            // a strobe arriving with the clearing read is kept
            status <= ((rd && is_status) ? '0 : status) | chan_reload_i;
            if (wr && is_ctrl) begin
                chan_enable_o  <= pwdata_i[`AUDIO_NCHAN-1:0];
                chan_restart_o <= pwdata_i[4 +: `AUDIO_NCHAN];
            end
            if (wr && is_chan) begin
                case (reg_sel)
                    REG_VOL: begin
                        vol_l[chan_idx] <= pwdata_i[13:8];
                        vol_r[chan_idx] <= pwdata_i[5:0];
                    end
                    REG_PERIOD: period[chan_idx] <= pwdata_i[14:0];
                    REG_START:  start[chan_idx]  <= pwdata_i[`AUDIO_VRAM_W-1:0];
                    default:    len[chan_idx]    <= pwdata_i[14:0];
                endcase
            end
        end
    end

    // flatten for the mixer
    always_comb begin
        for (int i = 0; i < `AUDIO_NCHAN; i++) begin
            chan_vol_l_o[6*i +: 6]                        = vol_l[i];
            chan_vol_r_o[6*i +: 6]                        = vol_r[i];
            chan_period_o[15*i +: 15]                     = period[i];
            chan_start_o[`AUDIO_VRAM_W*i +: `AUDIO_VRAM_W] = start[i];
            chan_len_o[15*i +: 15]                        = len[i];
        end
    end

endmodule

/* design/audio_sample_pkg.sv */
/*
 * sample data types for the audio block
 *   byte and word sample types, signed product type
 *   sample memory address type
 *   fetch and mix phase enums
 */
`include "audio_defines.svh"

package audio_sample_pkg;

    typedef logic [7:0]                 byte_t;     // one unsigned sample
    typedef logic signed [7:0]          sbyte_t;    // one signed sample
    typedef logic [15:0]                word_t;     // two samples, high byte first
    typedef logic signed [15:0]         sword_t;    // product or accumulator
    typedef logic [`AUDIO_VRAM_W-1:0]   addr_t;     // sample memory word address

    typedef enum logic {
        FETCH_DMA  = 1'b0,                          // pick channel, raise request
        FETCH_READ = 1'b1                           // wait for ack
    } fetch_phase_e;

    typedef enum logic {
        MIX_MULT  = 1'b0,                           // latch operands
        MIX_ACCUM = 1'b1                            // add product
    } mix_phase_e;

endpackage

/* design/audio_top.sv */
/*
 * audio block top level
 *   APB register slave, sample memory, mixer with PDM outputs
 */
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [`AUDIO_APB_AW-1:0]    paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [31:0]                 pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic                        pdm_l_o,
    output logic                        pdm_r_o
);
    import audio_sample_pkg::*;

    logic [`AUDIO_NCHAN-1:0]                chan_enable;
    logic [`AUDIO_NCHAN-1:0]                chan_restart;
    logic [`AUDIO_NCHAN-1:0]                chan_reload;
    logic [6*`AUDIO_NCHAN-1:0]              chan_vol_l;
    logic [6*`AUDIO_NCHAN-1:0]              chan_vol_r;
    logic [15*`AUDIO_NCHAN-1:0]             chan_period;
    logic [`AUDIO_VRAM_W*`AUDIO_NCHAN-1:0]  chan_start;
    logic [15*`AUDIO_NCHAN-1:0]             chan_len;
    logic                                   mem_we;
    addr_t                                  mem_waddr;
    word_t                                  mem_wdata;
    logic                                   fetch_req;
    logic                                   fetch_ack;
    addr_t                                  fetch_addr;
    word_t                                  fetch_word;

    audio_regs regs (
        .clk            (clk),            .reset_i        (reset_i),
        .paddr_i        (paddr_i),        .psel_i         (psel_i),
        .penable_i      (penable_i),      .pwrite_i       (pwrite_i),
        .pwdata_i       (pwdata_i),       .prdata_o       (prdata_o),
        .pready_o       (pready_o),       .pslverr_o      (pslverr_o),
        .chan_enable_o  (chan_enable),    .chan_restart_o (chan_restart),
        .chan_vol_l_o   (chan_vol_l),     .chan_vol_r_o   (chan_vol_r),
        .chan_period_o  (chan_period),    .chan_start_o   (chan_start),
        .chan_len_o     (chan_len),       .chan_reload_i  (chan_reload),
        .mem_we_o       (mem_we),         .mem_waddr_o    (mem_waddr),
        .mem_wdata_o    (mem_wdata)
    );

    sample_mem mem (
        .clk            (clk),            .reset_i        (reset_i),
        .mem_we_i       (mem_we),         .mem_waddr_i    (mem_waddr),
        .mem_wdata_i    (mem_wdata),      .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),     .fetch_ack_o    (fetch_ack),
        .fetch_word_o   (fetch_word)
    );

    audio_mixer mixer (
        .clk            (clk),            .reset_i        (reset_i),
        .chan_enable_i  (chan_enable),    .chan_restart_i (chan_restart),
        .chan_vol_l_i   (chan_vol_l),     .chan_vol_r_i   (chan_vol_r),
        .chan_period_i  (chan_period),    .chan_start_i   (chan_start),
        .chan_len_i     (chan_len),       .chan_reload_o  (chan_reload),
        .fetch_req_o    (fetch_req),      .fetch_addr_o   (fetch_addr),
        .fetch_ack_i    (fetch_ack),      .fetch_word_i   (fetch_word),
        .pdm_l_o        (pdm_l_o),        .pdm_r_o        (pdm_r_o)
    );

endmodule

/* design/sample_mem.sv */
/*
 * sample memory
 *   1K x 16 array, written from the APB side
 *   registered read answering request/acknowledge fetches
 */
`timescale 1ns/10ps
`include "audio_defines.svh"

module sample_mem (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        mem_we_i,
    input  audio_sample_pkg::addr_t     mem_waddr_i,
    input  audio_sample_pkg::word_t     mem_wdata_i,
    input  logic                        fetch_req_i,
    input  audio_sample_pkg::addr_t     fetch_addr_i,
    output logic                        fetch_ack_o,
    output audio_sample_pkg::word_t     fetch_word_o
);
    import audio_sample_pkg::*;

    word_t mem [2**`AUDIO_VRAM_W];

    always_ff @(posedge clk) begin
        if (mem_we_i) begin
            mem[mem_waddr_i] <= mem_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        fetch_word_o <= mem[fetch_addr_i];          // valid with the ack
    end

    // the requester still holds req in the ack cycle, so skip it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_ack_o <= 1'b0;
        end else begin
            fetch_ack_o <= fetch_req_i && !fetch_ack_o;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the audio block testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module audio_tb \
        -Mdir obj_dir -o audio_tb_sim \
    && out="$(./obj_dir/audio_tb_sim)" \
    || { echo "$out"; echo "build or run of the testbench failed"; exit 1; }

echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1

/* sim.f */
+incdir+design
design/audio_sample_pkg.sv
design/audio_regmap_pkg.sv
design/audio_dac.sv
design/sample_mem.sv
design/audio_regs.sv
design/audio_mixer.sv
design/audio_top.sv
verification/audio_tb.sv

/* verification/audio_patterns.txt */
# audio block steps, values in hex except the D and T counts
# W addr data | R addr data pslverr | L side(0 left, 1 right) level | D cycles | T test
# channel 2 registers read back, restart bits read as zero, bus errors
T 1
W 060 1523
W 064 7abc
W 068 02ab
W 06c 1234
R 060 1523 0
R 064 7abc 0
R 068 02ab 0
R 06c 1234 0
W 000 00f0
R 000 0000 0
R 008 0000 1
R 800 0000 1
# all channels off, both sides at mid scale
T 2
L 0 80
L 1 80
# channel 0 plays 0x20 at left volume 32, 32 x 64 = 0x800 gives 128 + 32
T 3
W 800 2020
W 040 2000
W 044 0003
W 048 0000
W 04c 0000
W 000 0001
R 000 0001 0
L 0 a0
L 1 80
# channel 1 adds -16 at volume 16 on both sides, left 0x600, right -0x200
T 4
W 810 f0f0
W 050 1010
W 054 0003
W 058 0008
W 000 0003
L 0 98
L 1 78
# sticky reload bits clear on read, then a one-word buffer runs out
T 5
W 000 0000
R 004 0003 0
R 004 0000 0
W 044 00c8
W 000 0001
D 20
R 004 0001 0
R 004 0000 0
D 420
R 004 0001 0
R 004 0000 0
# restart reloads channel 1 long before its buffer would run out
T 6
W 000 0000
R 004 0000 0
W 054 00c8
W 000 0002
D 20
R 004 0002 0
R 004 0000 0
W 000 0022
D 20
R 004 0002 0
R 004 0000 0

/* verification/audio_tb.sv */
/*
 * audio block testbench
 *   clock, reset and APB driver
 *   pattern file reader and step execution
 *   PDM ones counting, compare tasks, per-test and closing result lines
 */
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_tb;
    import audio_sample_pkg::*;

    localparam int HALF_PERIOD    = 20;             // 40 ns clock
    localparam int RESET_CYCLES   = 8;
    localparam int SETTLE_CYCLES  = 64;             // level reaches the DAC well within this
    localparam int MEASURE_CYCLES = 256;

    logic                       clk;
    logic                       reset_i;
    logic [`AUDIO_APB_AW-1:0]   paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       pdm_l;
    logic                       pdm_r;

    byte_t                      step_op [$];        // W R L D T
    logic [31:0]                step_a [$];
    logic [31:0]                step_b [$];
    logic [31:0]                step_c [$];

    int                         cycles;
    int                         cycle_limit;
    int                         checks;
    int                         errors;
    int                         test_id;
    int                         test_checks;
    int                         test_errors;

    audio_top uut (
        .clk        (clk),
        .reset_i    (reset_i),
        .paddr_i    (paddr),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .pdm_l_o    (pdm_l),
        .pdm_r_o    (pdm_r)
    );

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("ERROR %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("ERROR %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // a first-order DAC hits the level within one pulse over 256 cycles
    task automatic check_level(input string name, input byte_t expected, input int ones);
        checks++;
        test_checks++;
        if (ones < int'(expected) - 1 || ones > int'(expected) + 1) begin
            errors++;
            test_errors++;
            $display("ERROR %0t: %s expected %0d got %0d", $time, name, expected, ones);
        end
    endtask

    task automatic apb_write(input logic [`AUDIO_APB_AW-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;                             // ACCESS
        #(HALF_PERIOD / 2);
        check_flag("pready_o", 1'b1, pready);       // no wait states
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [`AUDIO_APB_AW-1:0] addr,
                            output logic [31:0] data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(HALF_PERIOD / 2);                         // mid low phase, away from the edge
        check_flag("pready_o", 1'b1, pready);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic measure_level(input logic side, input byte_t expected);
        int ones;
        ones = 0;
        repeat (SETTLE_CYCLES) @(negedge clk);
        repeat (MEASURE_CYCLES) begin
            @(negedge clk);                         // pulse changes on posedge
            ones = ones + int'(side ? pdm_r : pdm_l);
        end
        check_level(side ? "pdm_r_o" : "pdm_l_o", expected, ones);
    endtask

    task automatic load_patterns(output bit ok);
        int             fd;
        int             n;
        byte_t          op;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    c;
        logic [8*160-1:0] rest;
        ok = 1'b0;
        fd = $fopen("verification/audio_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            return;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            case (op)
                "#":      n = $fgets(rest, fd);     // comment line
                "W", "L": n = $fscanf(fd, " %h %h", a, b);
                "R":      n = $fscanf(fd, " %h %h %h", a, b, c);
                "D", "T": n = $fscanf(fd, " %d", a);
                default: begin
                    $display("pattern file holds an unknown step '%c'", op);
                    $fclose(fd);
                    return;
                end
            endcase
            if (op != "#") begin
                step_op.push_back(op);
                step_a.push_back(a);
                step_b.push_back(b);
                step_c.push_back(c);
            end
        end
        $fclose(fd);
        ok = step_op.size() > 0;
    endtask

    task automatic report_test();
        $display("test %0d %s: %0d checks, %0d errors", test_id,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    endtask

    initial begin
        bit             loaded;
        int             budget;
        logic [31:0]    rd_data;
        logic           rd_err;
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        reset_i     = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        test_id     = 0;
        test_checks = 0;
        test_errors = 0;
        budget      = 0;
        load_patterns(loaded);
        foreach (step_op[i]) begin
            if (step_op[i] == "D") begin
                budget += int'(step_a[i]);
            end else if (step_op[i] == "L") begin
                budget += SETTLE_CYCLES + MEASURE_CYCLES;
            end
        end
        cycle_limit = budget * 3 / 2;
        if (!loaded) begin
            $display("no steps could be read, nothing was tested");
            $display("Simulation failed");
        end else begin
            repeat (RESET_CYCLES) @(negedge clk);
            reset_i = 1'b0;
            foreach (step_op[i]) begin
                case (step_op[i])
                    "T": begin
                        if (test_id != 0) begin
                            report_test();
                        end
                        test_id     = int'(step_a[i]);
                        test_checks = 0;
                        test_errors = 0;
                    end
                    "W": apb_write(step_a[i][`AUDIO_APB_AW-1:0], step_b[i]);
                    "R": begin
                        apb_read(step_a[i][`AUDIO_APB_AW-1:0], rd_data, rd_err);
                        check_word("prdata_o[15:0]", step_b[i][15:0], rd_data[15:0]);
                        check_word("prdata_o[31:16]", step_b[i][31:16], rd_data[31:16]);
                        check_flag("pslverr_o", step_c[i][0], rd_err);
                    end
                    "L": measure_level(step_a[i][0], step_b[i][7:0]);
                    default: repeat (step_a[i]) @(negedge clk);
                endcase
            end
            if (test_id != 0) begin
                report_test();
            end
            $display("checks: %0d run, %0d passed, %0d failed", checks, checks - errors, errors);
            if (errors == 0 && checks > 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule
